//--- bench/tb_com_assertions.sv
// Transmit handshake properties for com_fifo_top; needs a simulator run with assertions enabled
`include "com_defs.svh"

module tb_com_assertions (
    input logic        clk,
    input logic        rst,
    input logic        i_tx_valid,
    input logic [31:0] i_tx_data,
    input logic [1:0]  i_tx_tag,
    input logic [1:0]  i_tx_ctx,
    input logic        i_tx_ready
);

    // Output register empties on every reset edge
    a_reset_idle: assert property (@(posedge clk) rst |=> !i_tx_valid)
        else $error("o_tx_valid high after a reset cycle");

    // Stalled word must not move
    a_hold: assert property (@(posedge clk) disable iff (rst)
        (i_tx_valid && !i_tx_ready) |=> (i_tx_valid && $stable(i_tx_data) &&
                                          $stable(i_tx_tag) && $stable(i_tx_ctx)))
        else $error("Transmit word changed while stalled");

    a_tag: assert property (@(posedge clk) disable iff (rst)
        i_tx_valid |-> (i_tx_tag == `TYPE_LOOP || i_tx_tag == `TYPE_CMD))
        else $error("o_tx_tag outside the loopback and command codes");

endmodule

bind com_fifo_top tb_com_assertions u_com_assertions (
    .clk        (clk),
    .rst        (rst),
    .i_tx_valid (o_tx_valid),
    .i_tx_data  (o_tx_data),
    .i_tx_tag   (o_tx_tag),
    .i_tx_ctx   (o_tx_ctx),
    .i_tx_ready (i_tx_ready)
);

//--- bench/tb_com_fifo.sv
// Directed tests of com_fifo_top; assumes 16-deep FIFOs and a 40-unit clock, stops at the first error
`include "com_defs.svh"

module tb_com_fifo;

    import com_pkg::*;

    localparam int TIMEOUT_CYCLES = 20000;  // Well above the few hundred cycles all tests need
    localparam int TX_WAIT        = 200;    // Per-word wait bound

    logic        clk;
    logic        rst;
    cmd_word_t   rx_data;
    logic        rx_valid;
    logic [31:0] tx_data;
    logic [1:0]  tx_tag;
    logic [1:0]  tx_ctx;
    logic        tx_valid;
    logic        tx_ready;

    logic [35:0] tx_q [$];                  // Seen transfers as {tag, ctx, data}
    logic [31:0] lfsr_state = 32'd82103;
    int          cycle_count = 0;

    com_fifo_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .i_rx_data  (rx_data),
        .i_rx_valid (rx_valid),
        .o_tx_data  (tx_data),
        .o_tx_tag   (tx_tag),
        .o_tx_ctx   (tx_ctx),
        .o_tx_valid (tx_valid),
        .i_tx_ready (tx_ready)
    );

    always #20 clk = ~clk;

    // Both sides steady mid-cycle, transfer lands on the next rising edge
    always @(negedge clk) begin
        if (tx_valid && tx_ready)
            tx_q.push_back({tx_tag, tx_ctx, tx_data});
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
            abort_run("Cycle limit reached before all tests finished");
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};     // x^32+x^22+x^2+x+1
    endfunction

    // One LFSR step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic cmd_word_t loop_frame(input logic [1:0] ctx, input logic [31:0] payload);
        cmd_word_t w;
        w             = '0;
        w[`F_MAGIC]   = `COM_MAGIC;
        w[`F_TYPE]    = `TYPE_LOOP;
        w[`F_CTX]     = ctx;
        w[`F_PAYLOAD] = payload;
        return w;
    endfunction

    function automatic cmd_word_t cmd_frame(input logic rd, input logic wr, input reg_addr_t addr,
                                            input reg_data_t mask, input reg_data_t value);
        cmd_word_t w;
        w           = '0;
        w[`F_MAGIC] = `COM_MAGIC;
        w[`F_TYPE]  = `TYPE_CMD;
        w[`F_RD]    = rd;
        w[`F_WR]    = wr;
        w[`F_ADDR]  = addr;
        w[`F_MASK]  = mask;
        w[`F_VALUE] = value;
        return w;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "Stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
            abort_run($sformatf("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    // Word is presented for one cycle, back to back when called in a row
    task automatic send_word(input cmd_word_t w);
        @(posedge clk);
        rx_data  <= w;
        rx_valid <= 1'b1;
    endtask

    task automatic end_burst();
        @(posedge clk);
        rx_valid <= 1'b0;
    endtask

    task automatic pop_tx(output logic [1:0] tag, output logic [1:0] ctx,
                          output logic [31:0] data);
        int          waited;
        logic [35:0] word;
        waited = 0;
        while (tx_q.size() == 0 && waited < TX_WAIT) begin
            @(posedge clk);
            waited++;
        end
        if (tx_q.size() == 0)
            abort_run("No transmit word arrived within the wait limit");
        else begin
            word = tx_q.pop_front();
            tag  = word[35:34];
            ctx  = word[33:32];
            data = word[31:0];
        end
    endtask

    task automatic expect_tx(input logic [1:0] tag, input logic [1:0] ctx,
                             input logic [31:0] data);
        logic [1:0]  got_tag;
        logic [1:0]  got_ctx;
        logic [31:0] got_data;
        pop_tx(got_tag, got_ctx, got_data);
        check_value("o_tx_tag", 64'(got_tag), 64'(tag));
        check_value("o_tx_ctx", 64'(got_ctx), 64'(ctx));
        check_value("o_tx_data", 64'(got_data), 64'(data));
    endtask

    // Read one half-word and check the response framing
    task automatic fetch_half(input reg_addr_t addr, output reg_data_t half);
        logic [1:0]  tag;
        logic [1:0]  ctx;
        logic [31:0] data;
        send_word(cmd_frame(1'b1, 1'b0, addr, 16'h0, 16'h0));
        end_burst();
        pop_tx(tag, ctx, data);
        check_value("o_tx_tag", 64'(tag), 64'(`TYPE_CMD));
        check_value("o_tx_ctx", 64'(ctx), 64'd0);
        check_value("o_tx_data[31:16]", 64'(data[31:16]), 64'(addr));   // Echoed address
        half = data[15:0];
    endtask

    task automatic verify_reg(input reg_addr_t addr, input reg_data_t exp);
        reg_data_t half;
        fetch_half(addr, half);
        check_value("o_tx_data[15:0]", 64'(half), 64'(exp));
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t mask, input reg_data_t value);
        send_word(cmd_frame(1'b0, 1'b1, addr, mask, value));
        end_burst();
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic reset_reads();
        repeat (5) @(posedge clk);
        check_value("tx_word_count", 64'(tx_q.size()), 64'd0);     // Quiet out of reset
        verify_reg(16'h0000, `RO_MAGIC);
        verify_reg(16'h0004, 16'(`RO_BYTES));
        verify_reg(16'h0008, {`VER_MINOR, `VER_MAJOR});             // Major in low byte
        verify_reg(16'h8000, `RW_MAGIC);
        verify_reg(16'h8004, 16'(`RW_BYTES));
    endtask

    task automatic loopback_order();
        logic [31:0] pay [20];
        logic [1:0]  ctx [20];
        int          i;
        for (i = 0; i < 20; i++) begin
            pay[i] = rand_bits(32);
            ctx[i] = 2'(rand_bits(2));
            send_word(loop_frame(ctx[i], pay[i]));
        end
        end_burst();
        for (i = 0; i < 20; i++)
            expect_tx(`TYPE_LOOP, ctx[i], pay[i]);
    endtask

    task automatic masked_writes();
        reg_data_t model [4];           // Expected scratch half-words
        reg_data_t mask;
        reg_data_t value;
        reg_addr_t addr;
        int        i;
        for (i = 0; i < 4; i++) begin
            addr     = 16'h8000 | 16'(`SCRATCH_OFS + 2 * i);
            model[i] = 16'(rand_bits(16));
            write_reg(addr, 16'hFFFF, model[i]);        // Full overwrite first
            mask     = 16'(rand_bits(16));
            value    = 16'(rand_bits(16));
            write_reg(addr, mask, value);
            model[i] = (model[i] & ~mask) | (value & mask);
        end
        for (i = 0; i < 4; i++)
            verify_reg(16'h8000 | 16'(`SCRATCH_OFS + 2 * i), model[i]);
        // Read plus write answers with the old value
        addr  = 16'h8000 | 16'(`SCRATCH_OFS);
        value = 16'(rand_bits(16));
        send_word(cmd_frame(1'b1, 1'b1, addr, 16'hFFFF, value));
        end_burst();
        expect_tx(`TYPE_CMD, 2'b00, {addr, model[0]});
        verify_reg(addr, value);
        write_reg(16'h0000, 16'hFFFF, 16'h1234);        // Read-only bank ignores it
        verify_reg(16'h0000, `RO_MAGIC);
        verify_reg(16'(`RO_BYTES), 16'h0000);           // Past ro end
        verify_reg(16'h8000 | 16'(`RW_BYTES), 16'h0000);
    endtask

    task automatic drop_filter();
        cmd_word_t w;
        w           = loop_frame(2'b01, 32'hDEAD_BEEF);
        w[`F_MAGIC] = 8'h76;
        send_word(w);                                   // Loopback with bad magic
        w           = cmd_frame(1'b1, 1'b0, 16'h0000, 16'h0, 16'h0);
        w[`F_MAGIC] = 8'hF7;
        send_word(w);
        w[`F_MAGIC] = `COM_MAGIC;
        w[`F_TYPE]  = 2'b00;                            // Old TLP type
        send_word(w);
        w[`F_TYPE]  = 2'b01;                            // Old CFG type
        send_word(w);
        end_burst();
        repeat (10) @(posedge clk);
        check_value("tx_word_count", 64'(tx_q.size()), 64'd0);
        verify_reg(16'h8000, `RW_MAGIC);
    endtask

    task automatic stall_priority();
        logic [31:0] pay [8];
        logic [1:0]  ctx [8];
        int          i;
        @(posedge clk);
        tx_ready <= 1'b0;
        for (i = 0; i < 8; i++) begin
            pay[i] = rand_bits(32);
            ctx[i] = 2'(rand_bits(2));
            send_word(loop_frame(ctx[i], pay[i]));
        end
        send_word(cmd_frame(1'b1, 1'b0, 16'h0000, 16'h0, 16'h0));
        send_word(cmd_frame(1'b1, 1'b0, 16'h0004, 16'h0, 16'h0));
        send_word(cmd_frame(1'b1, 1'b0, 16'h8000, 16'h0, 16'h0));
        send_word(cmd_frame(1'b1, 1'b0, 16'h8004, 16'h0, 16'h0));
        end_burst();
        repeat (20) @(posedge clk);
        @(negedge clk);
        // First loopback word parked in the output register
        check_value("o_tx_valid", 64'(tx_valid), 64'd1);
        check_value("o_tx_tag", 64'(tx_tag), 64'(`TYPE_LOOP));
        check_value("o_tx_ctx", 64'(tx_ctx), 64'(ctx[0]));
        check_value("o_tx_data", 64'(tx_data), 64'(pay[0]));
        @(posedge clk);
        tx_ready <= 1'b1;
        for (i = 0; i < 8; i++)
            expect_tx(`TYPE_LOOP, ctx[i], pay[i]);                  // Loopback drains first
        expect_tx(`TYPE_CMD, 2'b00, {16'h0000, `RO_MAGIC});
        expect_tx(`TYPE_CMD, 2'b00, {16'h0004, 16'(`RO_BYTES)});
        expect_tx(`TYPE_CMD, 2'b00, {16'h8000, `RW_MAGIC});
        expect_tx(`TYPE_CMD, 2'b00, {16'h8004, 16'(`RW_BYTES)});
    endtask

    task automatic uptime_count();
        logic [63:0] early_count;
        logic [63:0] late_count;
        reg_data_t   half;
        int          i;
        for (i = 0; i < 4; i++) begin
            fetch_half(16'(`UPTIME_OFS + 2 * i), half);
            early_count[16*i +: 16] = half;
        end
        repeat (50) @(posedge clk);
        for (i = 0; i < 4; i++) begin
            fetch_half(16'(`UPTIME_OFS + 2 * i), half);
            late_count[16*i +: 16] = half;
        end
        check_value("uptime_increased", 64'(late_count > early_count), 64'd1);
    endtask

    // ----------------------------------------
    // Sequence
    // ----------------------------------------
    initial begin
        clk      = 1'b0;
        rst      <= 1'b1;
        rx_data  <= '0;
        rx_valid <= 1'b0;
        tx_ready <= 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        reset_reads();
        loopback_order();
        masked_writes();
        drop_filter();
        stall_priority();
        uptime_count();
        repeat (10) @(posedge clk);
        if (tx_q.size() != 0)
            abort_run("Unexpected transmit words after the last test");
        else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- design/com_defs.svh
// Shared constants. Bank sizes must stay even, FIFO depths must be powers of two
`ifndef COM_DEFS_SVH
`define COM_DEFS_SVH

// ----------------------------------------
// Receive word decode
// ----------------------------------------
`define COM_MAGIC    8'h77       // Required in bits [7:0]
`define TYPE_LOOP    2'd2        // Loopback, also tx tag
`define TYPE_CMD     2'd3        // Command, also tx tag

`define F_MAGIC      7:0
`define F_TYPE       9:8
`define F_CTX        11:10       // Loopback context
`define F_RD         12          // Read flag
`define F_WR         13          // Write flag
`define F_ADDR       31:16       // Byte address, bit 15 picks rw bank
`define F_MASK       47:32
`define F_VALUE      63:48
`define F_PAYLOAD    63:32       // Loopback data

// ----------------------------------------
// Register banks
// ----------------------------------------
`define RO_MAGIC     16'hAB89
`define RW_MAGIC     16'hEFCD
`define RO_BYTES     32'd24
`define RW_BYTES     32'd16
`define MAGIC_OFS    0           // Both banks
`define BYTES_OFS    4           // Both banks, 32 bits
`define VER_OFS      8           // Major here, minor at +1
`define VER_MAJOR    8'h01
`define VER_MINOR    8'h02
`define UPTIME_OFS   16          // 64-bit free-running count
`define SCRATCH_OFS  8           // 64-bit scratch in rw bank

// ----------------------------------------
// Buffering
// ----------------------------------------
`define LOOP_DEPTH   16
`define CMD_DEPTH    16
`define CMD_AFULL    12          // Response FIFO stop level

`endif

//--- design/com_fifo_top.sv
// Host-link command and loopback unit; receive side has no ready, words to a full FIFO are lost
`include "com_defs.svh"

module com_fifo_top (
    input  logic               clk,
    input  logic               rst,
    input  com_pkg::cmd_word_t i_rx_data,
    input  logic               i_rx_valid,
    output logic [31:0]        o_tx_data,
    output logic [1:0]         o_tx_tag,
    output logic [1:0]         o_tx_ctx,
    output logic               o_tx_valid,
    input  logic               i_tx_ready
);

    import com_pkg::*;

    // Loopback path
    logic       loop_wr;
    loop_word_t loop_din;
    loop_word_t loop_dout;
    logic       loop_valid;
    logic       loop_pop;

    // Command path
    logic       cmd_wr;
    cmd_word_t  cmd_din;
    cmd_word_t  cmd_dout;
    logic       cmd_valid;
    logic       cmd_pop;

    // Register file access
    reg_addr_t  rd_addr;
    reg_data_t  rd_data;
    logic       wr_en;
    reg_addr_t  wr_addr;
    reg_data_t  wr_mask;
    reg_data_t  wr_value;

    // Response path
    logic       resp_wr;
    resp_word_t resp_din;
    resp_word_t resp_dout;
    logic       resp_valid;
    logic       resp_pop;
    logic       resp_afull;

    // ----------------------------------------
    // Receive side
    // ----------------------------------------
    rx_router u_rx_router (
        .i_rx_data   (i_rx_data),
        .i_rx_valid  (i_rx_valid),
        .o_loop_wr   (loop_wr),
        .o_loop_word (loop_din),
        .o_cmd_wr    (cmd_wr),
        .o_cmd_word  (cmd_din)
    );

    sync_fifo #(
        .DEPTH (`LOOP_DEPTH),
        .AFULL (`LOOP_DEPTH),
        .T     (loop_word_t)
    ) loop_fifo (
        .clk           (clk),
        .rst           (rst),
        .i_wr_en       (loop_wr),
        .i_din         (loop_din),
        .i_rd_en       (loop_pop),
        .o_dout        (loop_dout),
        .o_valid       (loop_valid),
        .o_full        (),
        .o_almost_full ()
    );

    sync_fifo #(
        .DEPTH (`CMD_DEPTH),
        .AFULL (`CMD_DEPTH),
        .T     (cmd_word_t)
    ) cmd_rx_fifo (
        .clk           (clk),
        .rst           (rst),
        .i_wr_en       (cmd_wr),
        .i_din         (cmd_din),
        .i_rd_en       (cmd_pop),
        .o_dout        (cmd_dout),
        .o_valid       (cmd_valid),
        .o_full        (),
        .o_almost_full ()
    );

    // ----------------------------------------
    // Command engine and registers
    // ----------------------------------------
    ctl_engine u_ctl_engine (
        .clk          (clk),
        .rst          (rst),
        .i_cmd_valid  (cmd_valid),
        .i_cmd_word   (cmd_dout),
        .o_cmd_pop    (cmd_pop),
        .o_rd_addr    (rd_addr),
        .i_rd_data    (rd_data),
        .o_wr_en      (wr_en),
        .o_wr_addr    (wr_addr),
        .o_wr_mask    (wr_mask),
        .o_wr_value   (wr_value),
        .o_resp_wr    (resp_wr),
        .o_resp_word  (resp_din),
        .i_resp_afull (resp_afull)
    );

    ctl_regfile u_ctl_regfile (
        .clk        (clk),
        .rst        (rst),
        .i_rd_addr  (rd_addr),
        .o_rd_data  (rd_data),
        .i_wr_en    (wr_en),
        .i_wr_addr  (wr_addr),
        .i_wr_mask  (wr_mask),
        .i_wr_value (wr_value)
    );

    sync_fifo #(
        .DEPTH (`CMD_DEPTH),
        .AFULL (`CMD_AFULL),
        .T     (resp_word_t)
    ) resp_fifo (
        .clk           (clk),
        .rst           (rst),
        .i_wr_en       (resp_wr),
        .i_din         (resp_din),
        .i_rd_en       (resp_pop),
        .o_dout        (resp_dout),
        .o_valid       (resp_valid),
        .o_full        (),
        .o_almost_full (resp_afull)
    );

    // ----------------------------------------
    // Transmit side
    // ----------------------------------------
    tx_arbiter u_tx_arbiter (
        .clk          (clk),
        .rst          (rst),
        .i_loop_valid (loop_valid),
        .i_loop_word  (loop_dout),
        .o_loop_pop   (loop_pop),
        .i_resp_valid (resp_valid),
        .i_resp_word  (resp_dout),
        .o_resp_pop   (resp_pop),
        .o_tx_data    (o_tx_data),
        .o_tx_tag     (o_tx_tag),
        .o_tx_ctx     (o_tx_ctx),
        .o_tx_valid   (o_tx_valid),
        .i_tx_ready   (i_tx_ready)
    );

endmodule

//--- design/com_pkg.sv
// Payload types of the host link; field layouts must match the receive word decode
package com_pkg;

    // Loopback entry, context rides above the data
    typedef struct packed {
        logic [1:0]  ctx;
        logic [31:0] data;
    } loop_word_t;

    // Full 64-bit receive word, kept whole for commands
    typedef logic [63:0] cmd_word_t;

    // Response entry, address in upper half of data
    typedef struct packed {
        logic [1:0]  ctx;
        logic [31:0] data;
    } resp_word_t;

    // Byte address; top bit picks rw bank, bit 0 ignored
    typedef logic [15:0] reg_addr_t;

    // One register half-word
    typedef logic [15:0] reg_data_t;

endpackage

//--- design/ctl_engine.sv
// Command executor; one command per cycle, stalls only on response FIFO almost-full
`include "com_defs.svh"

module ctl_engine (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_cmd_valid,
    input  com_pkg::cmd_word_t  i_cmd_word,
    output logic                o_cmd_pop,
    output com_pkg::reg_addr_t  o_rd_addr,
    input  com_pkg::reg_data_t  i_rd_data,
    output logic                o_wr_en,
    output com_pkg::reg_addr_t  o_wr_addr,
    output com_pkg::reg_data_t  o_wr_mask,
    output com_pkg::reg_data_t  o_wr_value,
    output logic                o_resp_wr,
    output com_pkg::resp_word_t o_resp_word,
    input  logic                i_resp_afull
);

    logic is_read;
    logic is_write;
    logic do_read;      // Response needed this cycle

    // ----------------------------------------
    // Command decode
    // ----------------------------------------
    assign is_read  = i_cmd_word[`F_RD];
    assign is_write = i_cmd_word[`F_WR];

    // Back-pressure from response side
    assign o_cmd_pop = i_cmd_valid & ~i_resp_afull;
    assign do_read   = o_cmd_pop & is_read;

    // Register file access, same address for both
    assign o_rd_addr  = i_cmd_word[`F_ADDR];
    assign o_wr_addr  = i_cmd_word[`F_ADDR];
    assign o_wr_mask  = i_cmd_word[`F_MASK];
    assign o_wr_value = i_cmd_word[`F_VALUE];
    assign o_wr_en    = o_cmd_pop & is_write;  // Commits at pop edge

    // ----------------------------------------
    // Response stage
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst)
            o_resp_wr <= 1'b0;
        else
            o_resp_wr <= do_read;
    end

    // Read data sampled before any write lands, so read+write returns old value
    always_ff @(posedge clk) begin
        if (do_read) begin
            o_resp_word.data <= {o_rd_addr, i_rd_data};
            o_resp_word.ctx  <= 2'b00;
        end
    end

endmodule

//--- design/ctl_regfile.sv
// Half-word register banks; reads are combinational, writes land on the clock edge, rw bank only
`include "com_defs.svh"

module ctl_regfile (
    input  logic               clk,
    input  logic               rst,
    input  com_pkg::reg_addr_t i_rd_addr,
    output com_pkg::reg_data_t o_rd_data,
    input  logic               i_wr_en,
    input  com_pkg::reg_addr_t i_wr_addr,
    input  com_pkg::reg_data_t i_wr_mask,
    input  com_pkg::reg_data_t i_wr_value
);

    import com_pkg::*;

    localparam int RO_BITS = `RO_BYTES * 8;
    localparam int RW_BITS = `RW_BYTES * 8;
    localparam int RO_IW   = $clog2(`RO_BYTES / 2);    // Half-word index widths
    localparam int RW_IW   = $clog2(`RW_BYTES / 2);

    logic [RO_BITS-1:0] ro;             // Constants plus uptime
    logic [RW_BITS-1:0] rw;             // Host-writable bank
    logic [63:0]        uptime;
    logic [RO_IW-1:0]   rd_ro_idx;
    logic [RW_IW-1:0]   rd_rw_idx;
    logic [RW_IW-1:0]   wr_idx;
    logic               rd_ro_hit;
    logic               rd_rw_hit;
    logic               wr_hit;
    reg_data_t          ro_half;
    reg_data_t          rw_half;

    // Free-running tick count
    always_ff @(posedge clk) begin
        if (rst)
            uptime <= '0;
        else
            uptime <= uptime + 64'd1;
    end

    // ----------------------------------------
    // Read-only bank
    // ----------------------------------------
    always_comb begin
        ro = '0;                                    // Gaps read zero
        ro[`MAGIC_OFS*8 +: 16]    = `RO_MAGIC;
        ro[`BYTES_OFS*8 +: 32]    = `RO_BYTES;
        ro[`VER_OFS*8 +: 8]       = `VER_MAJOR;
        ro[(`VER_OFS+1)*8 +: 8]   = `VER_MINOR;
        ro[`UPTIME_OFS*8 +: 64]   = uptime;
    end

    // ----------------------------------------
    // Read path
    // ----------------------------------------
    assign rd_ro_idx = i_rd_addr[RO_IW:1];          // Bit 0 dropped
    assign rd_rw_idx = i_rd_addr[RW_IW:1];
    assign rd_ro_hit = ~i_rd_addr[15] & (i_rd_addr[14:0] < 15'(`RO_BYTES));
    assign rd_rw_hit =  i_rd_addr[15] & (i_rd_addr[14:0] < 15'(`RW_BYTES));

    assign ro_half = ro[rd_ro_idx*16 +: 16];
    assign rw_half = rw[rd_rw_idx*16 +: 16];

    // Zero past either bank end
    assign o_rd_data = rd_ro_hit ? ro_half :
                       rd_rw_hit ? rw_half : '0;

    // ----------------------------------------
    // Write path
    // ----------------------------------------
    assign wr_idx = i_wr_addr[RW_IW:1];
    assign wr_hit = i_wr_en & i_wr_addr[15] & (i_wr_addr[14:0] < 15'(`RW_BYTES));

    always_ff @(posedge clk) begin
        if (rst) begin
            rw                        <= '0;
            rw[`MAGIC_OFS*8 +: 16]    <= `RW_MAGIC;
            rw[`BYTES_OFS*8 +: 32]    <= `RW_BYTES;
            rw[`SCRATCH_OFS*8 +: 64]  <= 64'h0;      // Scratch starts clear
        end
        else if (wr_hit) begin
            // Only mask-one bits change
            rw[wr_idx*16 +: 16] <= (rw[wr_idx*16 +: 16] & ~i_wr_mask) |
                                   (i_wr_value & i_wr_mask);
        end
    end

endmodule

//--- design/rx_router.sv
// Combinational receive decode; no back-pressure, so a word for a full FIFO is lost downstream
`include "com_defs.svh"

module rx_router (
    input  com_pkg::cmd_word_t  i_rx_data,
    input  logic                i_rx_valid,
    output logic                o_loop_wr,
    output com_pkg::loop_word_t o_loop_word,
    output logic                o_cmd_wr,
    output com_pkg::cmd_word_t  o_cmd_word
);

    logic magic_ok;     // Framing byte matches
    logic is_loop;
    logic is_cmd;

    assign magic_ok = i_rx_valid & (i_rx_data[`F_MAGIC] == `COM_MAGIC);
    assign is_loop  = (i_rx_data[`F_TYPE] == `TYPE_LOOP);
    assign is_cmd   = (i_rx_data[`F_TYPE] == `TYPE_CMD);

    // ----------------------------------------
    // FIFO write strobes
    // ----------------------------------------
    // Types 00 and 01 fall through here and vanish
    assign o_loop_wr = magic_ok & is_loop;
    assign o_cmd_wr  = magic_ok & is_cmd;

    // Loopback keeps payload and context only
    assign o_loop_word.data = i_rx_data[`F_PAYLOAD];
    assign o_loop_word.ctx  = i_rx_data[`F_CTX];

    assign o_cmd_word = i_rx_data;      // Engine decodes fields itself

endmodule

//--- design/sync_fifo.sv
// Show-ahead FIFO; DEPTH must be a power of two, writes when full and reads when empty are dropped
module sync_fifo #(
    parameter int  DEPTH = 16,
    parameter int  AFULL = 12,
    parameter type T     = logic [31:0]
) (
    input  logic clk,
    input  logic rst,
    input  logic i_wr_en,
    input  T     i_din,
    input  logic i_rd_en,
    output T     o_dout,
    output logic o_valid,
    output logic o_full,
    output logic o_almost_full
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    T               mem [DEPTH];    // Storage, no reset
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [CW-1:0]  count;          // Fill level
    logic           do_wr;
    logic           do_rd;

    assign do_wr = i_wr_en & ~o_full;     // Drop on full
    assign do_rd = i_rd_en & o_valid;     // Ignore on empty

    // ----------------------------------------
    // Status
    // ----------------------------------------
    assign o_valid       = (count != '0);
    assign o_full        = (count == CW'(DEPTH));
    assign o_almost_full = (count >= CW'(AFULL));
    assign o_dout        = mem[rd_ptr];   // Head word shown ahead

    // Pointers and fill count
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;    // Wraps at DEPTH
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
        end
    end

    // Payload write
    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= i_din;
    end

endmodule

//--- design/tx_arbiter.sv
// Two-source fixed-priority merge; loopback always wins, output held stable while not ready
`include "com_defs.svh"

module tx_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_loop_valid,
    input  com_pkg::loop_word_t i_loop_word,
    output logic                o_loop_pop,
    input  logic                i_resp_valid,
    input  com_pkg::resp_word_t i_resp_word,
    output logic                o_resp_pop,
    output logic [31:0]         o_tx_data,
    output logic [1:0]          o_tx_tag,
    output logic [1:0]          o_tx_ctx,
    output logic                o_tx_valid,
    input  logic                i_tx_ready
);

    logic take;         // Output slot free or draining

    assign take       = ~o_tx_valid | i_tx_ready;
    assign o_loop_pop = take & i_loop_valid;
    assign o_resp_pop = take & ~i_loop_valid & i_resp_valid;   // Only when loop empty

    // ----------------------------------------
    // Output register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst)
            o_tx_valid <= 1'b0;
        else if (take)
            o_tx_valid <= i_loop_valid | i_resp_valid;
    end

    always_ff @(posedge clk) begin
        if (o_loop_pop) begin
            o_tx_data <= i_loop_word.data;
            o_tx_tag  <= `TYPE_LOOP;
            o_tx_ctx  <= i_loop_word.ctx;
        end
        else if (o_resp_pop) begin
            o_tx_data <= i_resp_word.data;
            o_tx_tag  <= `TYPE_CMD;
            o_tx_ctx  <= i_resp_word.ctx;
        end
    end

endmodule

//--- files.f
+incdir+design
design/com_pkg.sv
design/sync_fifo.sv
design/rx_router.sv
design/ctl_regfile.sv
design/ctl_engine.sv
design/tx_arbiter.sv
design/com_fifo_top.sv
bench/tb_com_assertions.sv
bench/tb_com_fifo.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, exit status carries the result
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -f files.f --top-module tb_com_fifo &&
    ./obj_dir/Vtb_com_fifo ||
    { echo "Simulation run failed"; exit 1; }
